// File: spmm.f
logic/spmm_pkg.sv
logic/rhs_store.sv
logic/segment_decoder.sv
logic/segmented_reducer.sv
logic/pe_column.sv
logic/result_buffer.sv
logic/spmm_top.sv
verification/clock_gen.sv
verification/spmm_tb.sv

// File: verification/spmm_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spmm_tb import spmm_pkg::*; ();

    localparam int WAIT_LIMIT = 64;

    typedef struct packed {
        out_block_t block;
        logic [31:0] due_edge;
        logic [7:0] index;
    } expect_t;

    logic clock;
    logic reset;
    logic rhs_load;
    rhs_block_t rhs_block;
    logic rhs_ready;
    logic lhs_start;
    lhs_tile_t lhs_tile;
    logic lhs_ready;
    logic out_valid;
    out_block_t out_block;

    integer seed = 32'h8420_8640;
    int edge_count = 0;
    int mismatch_errors = 0;
    int timeout_errors = 0;
    int other_errors = 0;
    // what the DUT should hold after each accepted block
    rhs_matrix_t model_rhs = '0;
    expect_t exp_q[$];
    string name_q[$];

    clock_gen clock_gen0 (
        .clock (clock),
        .reset (reset)
    );

    spmm_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .rhs_load  (rhs_load),
        .rhs_block (rhs_block),
        .rhs_ready (rhs_ready),
        .lhs_start (lhs_start),
        .lhs_tile  (lhs_tile),
        .lhs_ready (lhs_ready),
        .out_valid (out_valid),
        .out_block (out_block)
    );

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    function automatic int rand_below(input int m);
        return $unsigned($random(seed)) % m;
    endfunction

    function automatic rhs_matrix_t random_matrix();
        rhs_matrix_t m;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                m[r][c] = data_t'($random(seed));
            end
        end
        return m;
    endfunction

    // kind 0 has N nonzeros and empty rows, kind 1 one dense row, kind 2 fewer than N
    function automatic lhs_tile_t make_tile(input int kind);
        lhs_tile_t t;
        int nnz;
        int ptr;
        int dense_row;
        for (int k = 0; k < N; k++) begin
            t.value[k] = data_t'($random(seed));
            t.col_idx[k] = LG_N'(rand_below(N));
        end
        dense_row = rand_below(N);
        nnz = (kind == 0) ? N : 1 + rand_below(N - 1);
        ptr = 0;
        for (int r = 0; r < N; r++) begin
            if (kind == 1) begin
                ptr = (r < dense_row) ? 0 : N;
            end else if (r == N - 1) begin
                ptr = nnz;
            end else begin
                // a step of zero leaves the row empty
                ptr = ptr + rand_below(3);
                if (ptr > nnz) begin
                    ptr = nnz;
                end
            end
            t.row_end[r] = PTR_W'(ptr);
        end
        return t;
    endfunction

    // row r covers nonzeros from the previous end pointer up to its own
    function automatic rhs_matrix_t reference_product(input lhs_tile_t t,
                                                      input rhs_matrix_t m);
        rhs_matrix_t res;
        int first;
        int last;
        data_t acc;
        first = 0;
        for (int r = 0; r < N; r++) begin
            last = t.row_end[r];
            for (int c = 0; c < N; c++) begin
                // 8-bit accumulator wraps modulo 256
                acc = '0;
                for (int k = first; k < last; k++) begin
                    acc = acc + t.value[k] * m[t.col_idx[k]][c];
                end
                res[r][c] = acc;
            end
            first = last;
        end
        return res;
    endfunction

    function automatic void push_expected(input rhs_matrix_t res, input string name,
                                          input int first_due);
        expect_t e;
        for (int b = 0; b < N_BLOCKS; b++) begin
            for (int i = 0; i < BLOCK_ROWS; i++) begin
                e.block[i] = res[b * BLOCK_ROWS + i];
            end
            e.due_edge = first_due + b;
            e.index = b;
            exp_q.push_back(e);
            name_q.push_back(name);
        end
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %b actual %b", name, expected, actual);
            mismatch_errors++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        lhs_start <= 1'b0;
        rhs_load <= 1'b0;
    endtask

    task automatic load_block(input rhs_matrix_t m, input int b);
        @(posedge clock);
        rhs_load <= 1'b1;
        for (int i = 0; i < BLOCK_ROWS; i++) begin
            rhs_block[i] <= m[b * BLOCK_ROWS + i];
        end
        @(negedge clock);
        assert (rhs_ready) else begin
            $display("rhs block %0d was not accepted", b);
            other_errors++;
        end
        if (rhs_ready) begin
            for (int i = 0; i < BLOCK_ROWS; i++) begin
                model_rhs[b * BLOCK_ROWS + i] = m[b * BLOCK_ROWS + i];
            end
        end
    endtask

    task automatic load_matrix(input rhs_matrix_t m);
        for (int b = 0; b < N_BLOCKS; b++) begin
            load_block(m, b);
        end
        idle_cycle();
    endtask

    // lhs_start stays high until the next driven edge
    task automatic start_tile(input lhs_tile_t t, input logic expect_accept,
                              input string name);
        rhs_matrix_t res;
        @(posedge clock);
        lhs_start <= 1'b1;
        lhs_tile <= t;
        @(negedge clock);
        assert (lhs_ready === expect_accept) else begin
            $display("%s: start %s", name,
                     lhs_ready ? "was accepted but should have been ignored"
                               : "was ignored but should have been accepted");
            other_errors++;
        end
        if (lhs_ready) begin
            res = reference_product(t, model_rhs);
            // first block after the sampling edge plus OUT_LATENCY-1 more edges
            push_expected(res, name, edge_count + OUT_LATENCY);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge clock);
        while (reset && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (!reset) else begin
            $display("timed out waiting for reset to be released");
            timeout_errors++;
        end
    endtask

    task automatic wait_lhs_ready(input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (!lhs_ready && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (lhs_ready) else begin
            $display("timed out waiting for lhs_ready (%s)", what);
            timeout_errors++;
        end
    endtask

    task automatic wait_rhs_ready(input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (!rhs_ready && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (rhs_ready) else begin
            $display("timed out waiting for rhs_ready (%s)", what);
            timeout_errors++;
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timed out with %0d result blocks still missing (%s)",
                     exp_q.size(), what);
            timeout_errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin : compare_blocks
        expect_t want;
        string test_name;
        if (!reset && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("out_valid was high at edge %0d with no block expected", edge_count);
                other_errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                test_name = name_q.pop_front();
                assert (out_block == want.block) else begin
                    $display("Mismatch %s block %0d: expected %h actual %h",
                             test_name, want.index, want.block, out_block);
                    mismatch_errors++;
                end
                assert (edge_count == want.due_edge) else begin
                    $display("Mismatch %s block %0d arrival edge: expected %0d actual %0d",
                             test_name, want.index, want.due_edge, edge_count);
                    mismatch_errors++;
                end
            end
        end
    end

    initial begin : stimulus
        rhs_matrix_t m;
        rhs_load <= 1'b0;
        rhs_block <= '0;
        lhs_start <= 1'b0;
        lhs_tile <= '0;
        wait_reset_release();
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset lhs_ready", 1'b0, lhs_ready);
        check_bit("reset rhs_ready", 1'b1, rhs_ready);

        start_tile(make_tile(0), 1'b0, "start before rhs full");
        idle_cycle();
        m = random_matrix();
        load_matrix(m);
        wait_lhs_ready("first rhs load");

        // isolated tiles
        for (int i = 0; i < 12; i++) begin
            wait_drain("single tiles");
            start_tile(make_tile(i % 3), 1'b1, "single tile");
            idle_cycle();
        end

        // starts N_BLOCKS cycles apart overlap in the pipeline
        wait_lhs_ready("overlapped tiles");
        for (int i = 0; i < 8; i++) begin
            start_tile(make_tile(i % 3), 1'b1, "overlapped tiles");
            repeat (N_BLOCKS - 1) idle_cycle();
        end

        wait_lhs_ready("spacing window");
        start_tile(make_tile(2), 1'b1, "spacing window");
        start_tile(make_tile(0), 1'b0, "start in spacing window");
        check_bit("rhs_ready with a tile in flight", 1'b0, rhs_ready);
        idle_cycle();

        // reload once the in-flight window is over
        wait_rhs_ready("reload");
        m = random_matrix();
        load_block(m, 0);
        idle_cycle();
        @(negedge clock);
        check_bit("lhs_ready during partial reload", 1'b0, lhs_ready);
        start_tile(make_tile(1), 1'b0, "start during partial reload");
        idle_cycle();
        for (int b = 1; b < N_BLOCKS; b++) begin
            load_block(m, b);
        end
        idle_cycle();
        wait_lhs_ready("reload done");
        for (int i = 0; i < 6; i++) begin
            start_tile(make_tile(i % 3), 1'b1, "after reload");
            repeat (N_BLOCKS - 1) idle_cycle();
        end

        wait_drain("end of run");
        // stray blocks would show up here
        repeat (2 * BUSY_CYCLES) idle_cycle();

        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_errors, timeout_errors, other_errors);
        if (mismatch_errors + timeout_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset held for 8 cycles
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/spmm_top.sv
`timescale 1ns/1ns
`default_nettype none

module spmm_top import spmm_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        rhs_load,
    input  wire rhs_block_t  rhs_block,
    output logic             rhs_ready,
    input  wire logic        lhs_start,
    input  wire lhs_tile_t   lhs_tile,
    output logic             lhs_ready,
    output logic             out_valid,
    output out_block_t       out_block
);

    logic lhs_accept;
    rhs_matrix_t rhs_matrix;
    seg_flags_t seg_flags;
    row_map_t row_map;
    logic map_valid;

    // column c of the RHS feeds column unit c
    data_vec_t [N-1:0] rhs_cols;
    col_results_t [N-1:0] col_results;

    rhs_store store0 (
        .clock      (clock),
        .reset      (reset),
        .rhs_load   (rhs_load),
        .rhs_block  (rhs_block),
        .lhs_start  (lhs_start),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .lhs_accept (lhs_accept),
        .rhs_matrix (rhs_matrix)
    );

    segment_decoder decoder0 (
        .clock      (clock),
        .reset      (reset),
        .lhs_accept (lhs_accept),
        .lhs_tile   (lhs_tile),
        .seg_flags  (seg_flags),
        .row_map    (row_map),
        .map_valid  (map_valid)
    );

    // transposed view of the stored matrix
    always_comb begin
        for (int c = 0; c < N; c++) begin
            for (int r = 0; r < N; r++) begin
                rhs_cols[c][r] = rhs_matrix[r][c];
            end
        end
    end

    for (genvar c = 0; c < N; c++) begin : gen_col
        pe_column column0 (
            .clock       (clock),
            .reset       (reset),
            .lhs_accept  (lhs_accept),
            .lhs_tile    (lhs_tile),
            .rhs_col     (rhs_cols[c]),
            .seg_flags   (seg_flags),
            .row_map     (row_map),
            .col_results (col_results[c])
        );
    end

    result_buffer buffer0 (
        .clock       (clock),
        .reset       (reset),
        .map_valid   (map_valid),
        .col_results (col_results),
        .out_valid   (out_valid),
        .out_block   (out_block)
    );

endmodule

`default_nettype wire

// File: logic/result_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module result_buffer import spmm_pkg::*; (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   map_valid,
    input  wire col_results_t [N-1:0]   col_results,
    output logic                        out_valid,
    output out_block_t                  out_block
);

    // result matrix by row
    data_vec_t [N-1:0] result_rows;
    logic [$clog2(N_BLOCKS)-1:0] blk_cnt;

    // columns arrive together and are stored transposed
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_rows <= '0;
        end else if (map_valid) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    result_rows[r][c] <= col_results[c][r];
                end
            end
        end
    end

    // block 0 goes out on the capture edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            blk_cnt <= '0;
        end else if (map_valid) begin
            out_valid <= 1'b1;
            blk_cnt <= '0;
        end else if (out_valid) begin
            if (blk_cnt == N_BLOCKS - 1) begin
                out_valid <= 1'b0;
                blk_cnt <= '0;
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    // current four rows
    always_comb begin
        for (int i = 0; i < BLOCK_ROWS; i++) begin
            out_block[i] = result_rows[blk_cnt * BLOCK_ROWS + i];
        end
    end

endmodule

`default_nettype wire

// File: logic/pe_column.sv
`timescale 1ns/1ns
`default_nettype none

module pe_column import spmm_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        lhs_accept,
    input  wire lhs_tile_t   lhs_tile,
    input  wire data_vec_t   rhs_col,
    input  wire seg_flags_t  seg_flags,
    input  wire row_map_t    row_map,
    output col_results_t     col_results
);

    data_vec_t products;
    data_vec_t sums;

    // one multiplier per nonzero with the result kept modulo 256
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            products <= '0;
        end else if (lhs_accept) begin
            for (int k = 0; k < N; k++) begin
                products[k] <= data_t'(lhs_tile.value[k] * rhs_col[lhs_tile.col_idx[k]]);
            end
        end
    end

    segmented_reducer reducer0 (
        .clock  (clock),
        .reset  (reset),
        .values (products),
        .heads  (seg_flags),
        .sums   (sums)
    );

    // row sum sits at the row's last nonzero
    always_comb begin
        for (int r = 0; r < N; r++) begin
            if (row_map.empty[r]) begin
                col_results[r] = '0;
            end else begin
                col_results[r] = sums[row_map.end_idx[r]];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/segmented_reducer.sv
`timescale 1ns/1ns
`default_nettype none

module segmented_reducer import spmm_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire data_vec_t   values,
    input  wire seg_flags_t  heads,
    output data_vec_t        sums
);

    // stage 0 is the input and stage LG_N the last register
    data_vec_t stage_val [LG_N+1];
    seg_flags_t stage_head [LG_N+1];

    assign stage_val[0] = values;
    assign stage_head[0] = heads;

    for (genvar s = 0; s < LG_N; s++) begin : gen_stage
        // distance 1, 2, 4
        localparam int DIST = 1 << s;

        always_ff @(posedge clock or posedge reset) begin
            int left;
            if (reset) begin
                stage_val[s+1] <= '0;
                stage_head[s+1] <= '0;
            end else begin
                for (int k = 0; k < N; k++) begin
                    left = (k >= DIST) ? k - DIST : k;
                    if (k >= DIST && !stage_head[s][k]) begin
                        // still inside the segment so pull in the left partial
                        stage_val[s+1][k] <= stage_val[s][k] + stage_val[s][left];
                        stage_head[s+1][k] <= stage_head[s][left];
                    end else begin
                        stage_val[s+1][k] <= stage_val[s][k];
                        stage_head[s+1][k] <= stage_head[s][k];
                    end
                end
            end
        end
    end

    // entry k holds its row's sum up to k
    assign sums = stage_val[LG_N];

endmodule

`default_nettype wire

// File: logic/segment_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module segment_decoder import spmm_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       lhs_accept,
    input  wire lhs_tile_t  lhs_tile,
    output seg_flags_t      seg_flags,
    output row_map_t        row_map,
    output logic            map_valid
);

    seg_flags_t heads_next;
    row_map_t map_next;
    logic [PTR_W-1:0] prev_end;
    logic [PTR_W-1:0] end_full;

    // delay line whose stage 0 loads on accept
    row_map_t map_pipe [LG_N+1];
    logic [LG_N:0] valid_pipe;

    // nonzero 0 always opens a segment
    always_comb begin
        heads_next = '0;
        heads_next[0] = 1'b1;
        for (int k = 1; k < N; k++) begin
            for (int r = 0; r < N; r++) begin
                if (lhs_tile.row_end[r] == PTR_W'(k)) begin
                    heads_next[k] = 1'b1;
                end
            end
        end
    end

    // end index and empty bit per row
    always_comb begin
        map_next = '0;
        prev_end = '0;
        end_full = '0;
        for (int r = 0; r < N; r++) begin
            end_full = lhs_tile.row_end[r] - 1'b1;
            map_next.end_idx[r] = end_full[LG_N-1:0];
            map_next.empty[r] = (lhs_tile.row_end[r] == prev_end);
            prev_end = lhs_tile.row_end[r];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seg_flags <= '0;
            valid_pipe <= '0;
            for (int i = 0; i <= LG_N; i++) begin
                map_pipe[i] <= '0;
            end
        end else begin
            valid_pipe <= {valid_pipe[LG_N-1:0], lhs_accept};
            if (lhs_accept) begin
                seg_flags <= heads_next;
                map_pipe[0] <= map_next;
            end
            // matches the reducer depth
            for (int i = 1; i <= LG_N; i++) begin
                map_pipe[i] <= map_pipe[i-1];
            end
        end
    end

    assign row_map = map_pipe[LG_N];
    assign map_valid = valid_pipe[LG_N];

endmodule

`default_nettype wire

// File: logic/rhs_store.sv
`timescale 1ns/1ns
`default_nettype none

module rhs_store import spmm_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        rhs_load,
    input  wire rhs_block_t  rhs_block,
    input  wire logic        lhs_start,
    output logic             rhs_ready,
    output logic             lhs_ready,
    output logic             lhs_accept,
    output rhs_matrix_t      rhs_matrix
);

    typedef logic [$clog2(BUSY_CYCLES+1)-1:0] busy_cnt_t;
    typedef logic [$clog2(N_BLOCKS+1)-1:0] space_cnt_t;

    logic [$clog2(N_BLOCKS)-1:0] blk_cnt;
    logic full;
    busy_cnt_t busy_cnt;
    space_cnt_t space_cnt;

    // no reload while a tile is in flight
    assign rhs_ready = (busy_cnt == '0);
    assign lhs_ready = full && (blk_cnt == '0) && (space_cnt == '0);
    assign lhs_accept = lhs_start && lhs_ready;

    // block writes and full flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            blk_cnt <= '0;
            full <= 1'b0;
            rhs_matrix <= '0;
        end else if (rhs_load && rhs_ready) begin
            for (int i = 0; i < BLOCK_ROWS; i++) begin
                rhs_matrix[blk_cnt * BLOCK_ROWS + i] <= rhs_block[i];
            end
            if (blk_cnt == N_BLOCKS - 1) begin
                blk_cnt <= '0;
                full <= 1'b1;
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
                // first block of a reload
                if (blk_cnt == '0) begin
                    full <= 1'b0;
                end
            end
        end
    end

    // in-flight window and start spacing
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_cnt <= '0;
            space_cnt <= '0;
        end else if (lhs_accept) begin
            busy_cnt <= busy_cnt_t'(BUSY_CYCLES);
            space_cnt <= space_cnt_t'(N_BLOCKS - 1);
        end else begin
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            if (space_cnt != '0) begin
                space_cnt <= space_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/spmm_pkg.sv
`default_nettype none

package spmm_pkg;

    // matrix size and nonzero capacity of one tile
    localparam int N = 8;
    localparam int LG_N = 3;
    localparam int DATA_W = 8;
    // wide enough to hold the value N
    localparam int PTR_W = LG_N + 1;

    // transfer shape
    localparam int BLOCK_ROWS = 4;
    localparam int N_BLOCKS = N / BLOCK_ROWS;

    // edges from the start strobe to the first result block
    localparam int OUT_LATENCY = LG_N + 2;
    localparam int BUSY_CYCLES = OUT_LATENCY + N_BLOCKS;

    typedef logic [DATA_W-1:0] data_t;
    typedef data_t [N-1:0] data_vec_t;

    typedef data_vec_t [BLOCK_ROWS-1:0] rhs_block_t;
    typedef data_vec_t [BLOCK_ROWS-1:0] out_block_t;
    typedef data_vec_t [N-1:0] rhs_matrix_t;

    // compressed-row tile
    typedef struct packed {
        logic [N-1:0][PTR_W-1:0] row_end;
        logic [N-1:0][LG_N-1:0] col_idx;
        data_vec_t value;
    } lhs_tile_t;

    // bit k marks the first nonzero of a row
    typedef logic [N-1:0] seg_flags_t;

    // which scan entry closes each row
    typedef struct packed {
        logic [N-1:0][LG_N-1:0] end_idx;
        logic [N-1:0] empty;
    } row_map_t;

    typedef data_vec_t col_results_t;

endpackage

`default_nettype wire
